// ==== src/readout_defines.svh ====
`ifndef READOUT_DEFINES_SVH
`define READOUT_DEFINES_SVH

//////////////////////////////////////////////////////////////////////
// Array geometry
//////////////////////////////////////////////////////////////////////

// ROIC line memories on the shared bus
`define NUM_ROIC 12
// Words per memory per line
`define WORDS_PER_ROIC 128
// One channel sample
`define DATA_W 24

//////////////////////////////////////////////////////////////////////
// Timing
//////////////////////////////////////////////////////////////////////

// Request edge to data on bank bus
`define MEM_LATENCY 2
// Idle cycles after the last word of a line
`define LINE_GAP 6
// Read index rise to frame reset pulse
`define FRAME_RESET_DELAY 4

`endif

// ==== src/readout_pkg.sv ====
`default_nettype none

`include "readout_defines.svh"

package readout_pkg;

    // One word from a ROIC memory with both channels
    typedef struct packed {
        logic [`DATA_W-1:0] a;
        logic [`DATA_W-1:0] b;
    } bank_word_t;

    // Shared read data bus with one word slot per bank
    typedef bank_word_t [`NUM_ROIC-1:0] bank_bus_t;

    // One-hot bank select
    typedef logic [`NUM_ROIC-1:0] bank_grant_t;

    // Word position inside one bank
    typedef logic [$clog2(`WORDS_PER_ROIC)-1:0] word_idx_t;

    // Lines per frame
    typedef logic [15:0] line_cnt_t;

    // Output beat with its framing flags
    typedef struct packed {
        bank_word_t data;
        logic       first;
        logic       last;
    } beat_t;

    // Line sequencer FSM
    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_READ,
        SEQ_GAP
    } seq_state_e;

endpackage

`default_nettype wire

// ==== src/frame_timing.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "readout_defines.svh"

module frame_timing (
    input  logic                  eim_clk,
    input  logic                  rst_n_eim,
    input  logic                  read_index,
    input  readout_pkg::line_cnt_t dsp_image_height,
    input  logic                  line_done,
    output logic                  frame_reset,
    output logic                  line_allowed
);

    import readout_pkg::*;

    // Read index history with the oldest sample at the top
    logic [`FRAME_RESET_DELAY-1:0] index_sr;
    // Last stage one cycle later for edge detect
    logic                          index_last;
    // Lines finished since the last frame reset
    line_cnt_t                     line_cnt;

    //////////////////////////////////////////////////////////////////
    // Delayed frame reset
    //////////////////////////////////////////////////////////////////

    always_ff @(posedge eim_clk or negedge rst_n_eim) begin
        if (!rst_n_eim) begin
            index_sr   <= '0;
            index_last <= 1'b0;
        end else begin
            index_sr   <= {index_sr[`FRAME_RESET_DELAY-2:0], read_index};
            index_last <= index_sr[`FRAME_RESET_DELAY-1];
        end
    end

    // Rise seen at the end of the chain
    // Single pulse per readout window
    assign frame_reset = index_sr[`FRAME_RESET_DELAY-1] & ~index_last;

    //////////////////////////////////////////////////////////////////
    // Line count against image height
    //////////////////////////////////////////////////////////////////

    always_ff @(posedge eim_clk or negedge rst_n_eim) begin
        if (!rst_n_eim) begin
            line_cnt <= '0;
        end else if (frame_reset) begin
            // Frame reset wins over a finishing line
            line_cnt <= '0;
        end else if (line_done) begin
            line_cnt <= line_cnt + 1'b1;
        end
    end

    // Follows line_done by one cycle
    assign line_allowed = (line_cnt < dsp_image_height);

endmodule

`default_nettype wire

// ==== src/bank_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "readout_defines.svh"

module bank_sequencer (
    input  logic                     eim_clk,
    input  logic                     rst_n_eim,
    input  logic                     read_index,
    input  logic                     read_data_start,
    input  logic                     csi_done,
    input  logic                     read_axis_tready,
    input  logic                     frame_reset,
    input  logic                     line_allowed,
    output readout_pkg::bank_grant_t req_grant,
    output logic                     req_first,
    output logic                     req_last,
    output logic                     line_done
);

    import readout_pkg::*;

    localparam int GAP_W = $clog2(`LINE_GAP + 1);

    seq_state_e       state;
    // Bank currently holding the bus
    bank_grant_t      grant;
    word_idx_t        word_idx;
    logic [GAP_W-1:0] gap_cnt;
    // Next request opens a frame
    logic             first_pending;

    logic             start_ok;
    logic             advance;
    logic             last_word;
    logic             last_bank;
    logic             gap_done;

    //////////////////////////////////////////////////////////////////
    // Request conditions
    //////////////////////////////////////////////////////////////////

    // Start only from idle, inside a readout window, below height
    assign start_ok  = (state == SEQ_IDLE) && read_data_start && read_index && line_allowed;
    // One word per permitted cycle
    assign advance   = (state == SEQ_READ) && read_axis_tready && csi_done;
    assign last_word = (word_idx == word_idx_t'(`WORDS_PER_ROIC - 1));
    assign last_bank = grant[`NUM_ROIC-1];
    assign gap_done  = (gap_cnt == GAP_W'(`LINE_GAP - 1));

    // Grant doubles as the request strobe
    assign req_grant = advance ? grant : '0;
    assign req_first = advance && first_pending;
    assign req_last  = advance && last_word && last_bank;
    assign line_done = req_last;

    //////////////////////////////////////////////////////////////////
    // Sequencer FSM
    //////////////////////////////////////////////////////////////////

    always_ff @(posedge eim_clk or negedge rst_n_eim) begin
        if (!rst_n_eim) begin
            state    <= SEQ_IDLE;
            grant    <= '0;
            word_idx <= '0;
            gap_cnt  <= '0;
        end else if (frame_reset) begin
            // Abort any line in progress
            state    <= SEQ_IDLE;
            grant    <= '0;
            word_idx <= '0;
            gap_cnt  <= '0;
        end else begin
            case (state)
                SEQ_IDLE: begin
                    if (start_ok) begin
                        state    <= SEQ_READ;
                        grant    <= bank_grant_t'(1);
                        word_idx <= '0;
                    end
                end
                SEQ_READ: begin
                    if (advance) begin
                        if (last_word) begin
                            word_idx <= '0;
                            if (last_bank) begin
                                // Line complete so the bus is released
                                state   <= SEQ_GAP;
                                grant   <= '0;
                                gap_cnt <= '0;
                            end else begin
                                grant <= {grant[`NUM_ROIC-2:0], 1'b0};
                            end
                        end else begin
                            word_idx <= word_idx + 1'b1;
                        end
                    end
                end
                SEQ_GAP: begin
                    if (gap_done) begin
                        state <= SEQ_IDLE;
                    end else begin
                        gap_cnt <= gap_cnt + 1'b1;
                    end
                end
                default: state <= SEQ_IDLE;
            endcase
        end
    end

    // Frame start tag armed by frame reset
    always_ff @(posedge eim_clk or negedge rst_n_eim) begin
        if (!rst_n_eim) begin
            first_pending <= 1'b0;
        end else if (frame_reset) begin
            first_pending <= 1'b1;
        end else if (advance) begin
            first_pending <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== src/read_data_mux.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "readout_defines.svh"

module read_data_mux (
    input  logic                     eim_clk,
    input  logic                     rst_n_eim,
    input  readout_pkg::bank_grant_t req_grant,
    input  logic                     req_first,
    input  logic                     req_last,
    input  readout_pkg::bank_bus_t   roic_read_data,
    output readout_pkg::beat_t       beat_out,
    output logic                     beat_valid
);

    import readout_pkg::*;

    // Request tags in flight
    // Stage k is seen k+1 cycles after the request
    bank_grant_t                grant_pipe [`MEM_LATENCY];
    logic [`MEM_LATENCY-1:0]    first_pipe;
    logic [`MEM_LATENCY-1:0]    last_pipe;
    bank_grant_t                grant_due;
    bank_word_t                 word_sel;

    //////////////////////////////////////////////////////////////////
    // Latency alignment
    //////////////////////////////////////////////////////////////////

    always_ff @(posedge eim_clk or negedge rst_n_eim) begin
        if (!rst_n_eim) begin
            for (int k = 0; k < `MEM_LATENCY; k++) begin
                grant_pipe[k] <= '0;
            end
            first_pipe <= '0;
            last_pipe  <= '0;
        end else begin
            grant_pipe[0] <= req_grant;
            for (int k = 1; k < `MEM_LATENCY; k++) begin
                grant_pipe[k] <= grant_pipe[k-1];
            end
            first_pipe <= {first_pipe[`MEM_LATENCY-2:0], req_first};
            last_pipe  <= {last_pipe[`MEM_LATENCY-2:0], req_last};
        end
    end

    // Grant matching the word now on the bus
    assign grant_due = grant_pipe[`MEM_LATENCY-1];

    // One-hot select that gives zero when idle
    always_comb begin
        word_sel = '0;
        for (int b = 0; b < `NUM_ROIC; b++) begin
            if (grant_due[b]) begin
                word_sel = word_sel | roic_read_data[b];
            end
        end
    end

    //////////////////////////////////////////////////////////////////
    // Output beat register
    //////////////////////////////////////////////////////////////////

    always_ff @(posedge eim_clk or negedge rst_n_eim) begin
        if (!rst_n_eim) begin
            beat_valid <= 1'b0;
            beat_out   <= '0;
        end else begin
            beat_valid     <= |grant_due;
            beat_out.data  <= word_sel;
            beat_out.first <= first_pipe[`MEM_LATENCY-1];
            beat_out.last  <= last_pipe[`MEM_LATENCY-1];
        end
    end

endmodule

`default_nettype wire

// ==== src/readout_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "readout_defines.svh"

module readout_top (
    input  logic                     eim_clk,
    input  logic                     rst_n_eim,
    input  logic                     read_index,
    input  logic                     read_data_start,
    input  logic                     csi_done,
    input  logic                     read_axis_tready,
    input  readout_pkg::line_cnt_t   dsp_image_height,
    input  readout_pkg::bank_bus_t   roic_read_data,
    output readout_pkg::bank_grant_t data_read_req,
    output logic                     read_data_valid,
    output logic [`DATA_W-1:0]       read_data_a,
    output logic [`DATA_W-1:0]       read_data_b,
    output logic                     read_axis_tlast,
    output logic                     read_frame_start,
    output logic                     read_frame_reset
);

    import readout_pkg::*;

    logic        frame_reset;
    logic        line_allowed;
    logic        line_done;
    bank_grant_t req_grant;
    logic        req_first;
    logic        req_last;
    beat_t       beat_out;

    //////////////////////////////////////////////////////////////////
    // Frame and line bookkeeping
    //////////////////////////////////////////////////////////////////

    frame_timing frame_timing_i (
        .eim_clk          (eim_clk),
        .rst_n_eim        (rst_n_eim),
        .read_index       (read_index),
        .dsp_image_height (dsp_image_height),
        .line_done        (line_done),
        .frame_reset      (frame_reset),
        .line_allowed     (line_allowed)
    );

    // Bus arbiter in bank order
    bank_sequencer bank_sequencer_i (
        .eim_clk          (eim_clk),
        .rst_n_eim        (rst_n_eim),
        .read_index       (read_index),
        .read_data_start  (read_data_start),
        .csi_done         (csi_done),
        .read_axis_tready (read_axis_tready),
        .frame_reset      (frame_reset),
        .line_allowed     (line_allowed),
        .req_grant        (req_grant),
        .req_first        (req_first),
        .req_last         (req_last),
        .line_done        (line_done)
    );

    // Returned word select
    read_data_mux read_data_mux_i (
        .eim_clk          (eim_clk),
        .rst_n_eim        (rst_n_eim),
        .req_grant        (req_grant),
        .req_first        (req_first),
        .req_last         (req_last),
        .roic_read_data   (roic_read_data),
        .beat_out         (beat_out),
        .beat_valid       (read_data_valid)
    );

    // Grant goes straight out as memory request
    assign data_read_req    = req_grant;
    assign read_frame_reset = frame_reset;

    // Beat fields onto ports
    assign read_data_a      = beat_out.data.a;
    assign read_data_b      = beat_out.data.b;
    assign read_axis_tlast  = beat_out.last;
    assign read_frame_start = beat_out.first;

endmodule

`default_nettype wire

// ==== dv/tb_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic eim_clk
);

    // Half of the 8 ns period
    localparam time HALF_PERIOD = 4ns;

    initial begin
        eim_clk = 1'b0;
        forever begin
            #HALF_PERIOD eim_clk = ~eim_clk;
        end
    end

endmodule

`default_nettype wire

// ==== dv/tb_readout_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "readout_defines.svh"

module tb_readout_top;

    import readout_pkg::*;

    logic        eim_clk;
    logic        rst_n_eim;
    logic        read_index;
    logic        read_data_start;
    logic        csi_done;
    logic        read_axis_tready;
    line_cnt_t   dsp_image_height;
    bank_bus_t   roic_read_data;
    bank_grant_t data_read_req;
    logic        read_data_valid;
    logic [`DATA_W-1:0] read_data_a;
    logic [`DATA_W-1:0] read_data_b;
    logic        read_axis_tlast;
    logic        read_frame_start;
    logic        read_frame_reset;

    // Test records of four hex words each
    logic [15:0] test_mem [64];
    int          num_recs;
    int          limit_cycles;
    integer      seed;
    int          stall_pct;
    int          csi_gap_pct;
    int          cycle_cnt;

    // Scoreboard state
    beat_t       exp_q [$];
    beat_t       exp_beat;
    bank_word_t  got_word;
    int          line_seq;
    int          line_ends;
    int          reset_cnt;
    int          reset_cycle;
    int          beat_cnt;
    int          mismatch_cnt;
    int          fail_cnt;

    // Bank model state per cycle and per bank
    int          req_bank;
    int          pend_bank [`MEM_LATENCY];
    int          bank_words [`NUM_ROIC];
    int          bank_lines [`NUM_ROIC];
    int          ret_bank;
    bank_bus_t   bus_next;

    tb_clock_gen clock_gen_i (
        .eim_clk (eim_clk)
    );

    readout_top readout_top_i (
        .eim_clk          (eim_clk),
        .rst_n_eim        (rst_n_eim),
        .read_index       (read_index),
        .read_data_start  (read_data_start),
        .csi_done         (csi_done),
        .read_axis_tready (read_axis_tready),
        .dsp_image_height (dsp_image_height),
        .roic_read_data   (roic_read_data),
        .data_read_req    (data_read_req),
        .read_data_valid  (read_data_valid),
        .read_data_a      (read_data_a),
        .read_data_b      (read_data_b),
        .read_axis_tlast  (read_axis_tlast),
        .read_frame_start (read_frame_start),
        .read_frame_reset (read_frame_reset)
    );

    //////////////////////////////////////////////////////////////////////
    // Word pattern and checks
    //////////////////////////////////////////////////////////////////////

    // Marker nibble, line, bank and word index
    // Field b is the inverse of field a
    function automatic bank_word_t make_word(input int bank, input int line, input int word);
        bank_word_t w;
        w.a = {4'ha, line[7:0], bank[3:0], 1'b0, word[6:0]};
        w.b = ~w.a;
        return w;
    endfunction

    task automatic compare_word(input string name, input bank_word_t got, input bank_word_t exp);
        if (got !== exp) begin
            mismatch_cnt++;
            $display("mismatch at %0d ns on %s: got %h/%h, expected %h/%h",
                     $time, name, got.a, got.b, exp.a, exp.b);
        end
    endtask

    task automatic compare_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            mismatch_cnt++;
            $display("mismatch at %0d ns on %s: got %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic compare_grant(input string name, input bank_grant_t got,
                                 input bank_grant_t exp);
        if (got !== exp) begin
            mismatch_cnt++;
            $display("mismatch at %0d ns on %s: got %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic compare_count(input string name, input line_cnt_t got, input line_cnt_t exp);
        if (got !== exp) begin
            mismatch_cnt++;
            $display("mismatch at %0d ns on %s: got %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic report_failure(input string what);
        fail_cnt++;
        $display("error at %0d ns: %s", $time, what);
    endtask

    // All expected beats of one line in bank order then word order
    task automatic push_line(input bit frame_first);
        beat_t beat;
        for (int b = 0; b < `NUM_ROIC; b++) begin
            for (int w = 0; w < `WORDS_PER_ROIC; w++) begin
                beat.data  = make_word(b, line_seq, w);
                beat.first = frame_first && (b == 0) && (w == 0);
                beat.last  = (b == `NUM_ROIC - 1) && (w == `WORDS_PER_ROIC - 1);
                exp_q.push_back(beat);
            end
        end
        line_seq++;
    endtask

    //////////////////////////////////////////////////////////////////////
    // Bank model and random stalls
    //////////////////////////////////////////////////////////////////////

    always @(posedge eim_clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    initial begin
        roic_read_data = '0;
        req_bank       = -1;
        for (int k = 0; k < `MEM_LATENCY; k++) begin
            pend_bank[k] = -1;
        end
        for (int b = 0; b < `NUM_ROIC; b++) begin
            bank_words[b] = 0;
            bank_lines[b] = 0;
        end
        forever begin
            @(posedge eim_clk);
            #1;
            // Oldest stage is the word due on the bus this cycle
            for (int k = `MEM_LATENCY - 1; k > 0; k--) begin
                pend_bank[k] = pend_bank[k-1];
            end
            pend_bank[0] = req_bank;
            // Idle banks show junk the mux must not pick
            for (int b = 0; b < `NUM_ROIC; b++) begin
                bus_next[b].a = `DATA_W'(cycle_cnt);
                bus_next[b].b = `DATA_W'(b);
            end
            ret_bank = pend_bank[`MEM_LATENCY-1];
            if (ret_bank >= 0) begin
                bus_next[ret_bank] = make_word(ret_bank, bank_lines[ret_bank],
                                               bank_words[ret_bank]);
                bank_words[ret_bank]++;
                if (bank_words[ret_bank] == `WORDS_PER_ROIC) begin
                    bank_words[ret_bank] = 0;
                    bank_lines[ret_bank]++;
                end
            end
            roic_read_data = bus_next;
        end
    end

    initial begin
        seed             = 95;
        read_axis_tready = 1'b1;
        csi_done         = 1'b1;
        forever begin
            @(posedge eim_clk);
            #1;
            read_axis_tready = ($unsigned($random(seed)) % 100) >= stall_pct;
            csi_done         = ($unsigned($random(seed)) % 100) >= csi_gap_pct;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Output monitor sampled mid-cycle
    //////////////////////////////////////////////////////////////////////

    always @(negedge eim_clk) begin
        // Request capture for the bank model
        req_bank = -1;
        for (int b = 0; b < `NUM_ROIC; b++) begin
            if (data_read_req[b]) begin
                req_bank = b;
            end
        end
        if (rst_n_eim) begin
            if ($countones(data_read_req) > 1) begin
                report_failure("more than one bank requested in one cycle");
            end
            // Stalled cycles carry no request
            if (!read_axis_tready || !csi_done) begin
                compare_grant("data_read_req", data_read_req, '0);
            end
            if (read_frame_reset) begin
                reset_cnt++;
                reset_cycle = cycle_cnt;
            end
            if (read_data_valid) begin
                beat_cnt++;
                if (exp_q.size() == 0) begin
                    report_failure("beat arrived while no beat was expected");
                end else begin
                    exp_beat   = exp_q.pop_front();
                    got_word.a = read_data_a;
                    got_word.b = read_data_b;
                    compare_word("read_data", got_word, exp_beat.data);
                    compare_flag("read_axis_tlast", read_axis_tlast, exp_beat.last);
                    compare_flag("read_frame_start", read_frame_start, exp_beat.first);
                end
                if (read_axis_tlast) begin
                    line_ends++;
                end
            end else begin
                compare_flag("read_axis_tlast", read_axis_tlast, 1'b0);
                compare_flag("read_frame_start", read_frame_start, 1'b0);
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////////////////////////

    task automatic next_cycle();
        @(posedge eim_clk);
        #1;
    endtask

    task automatic pulse_start();
        read_data_start = 1'b1;
        next_cycle();
        read_data_start = 1'b0;
    endtask

    // Idle outputs right after reset
    task automatic check_quiet();
        repeat (8) begin
            @(negedge eim_clk);
            compare_grant("data_read_req", data_read_req, '0);
            compare_flag("read_data_valid", read_data_valid, 1'b0);
            compare_flag("read_axis_tlast", read_axis_tlast, 1'b0);
            compare_flag("read_frame_start", read_frame_start, 1'b0);
            compare_flag("read_frame_reset", read_frame_reset, 1'b0);
        end
        next_cycle();
    endtask

    // One readout window with its line starts
    task automatic run_frame(input int height, input int starts, input int stall,
                             input int gap);
        int ends0;
        int resets0;
        int rise_cycle;
        int accepted;
        int wait_cnt;
        int exp_lines;
        dsp_image_height = line_cnt_t'(height);
        stall_pct        = stall;
        csi_gap_pct      = gap;
        accepted         = 0;
        wait_cnt         = 0;
        exp_lines        = (starts < height) ? starts : height;
        ends0            = line_ends;
        resets0          = reset_cnt;
        read_index       = 1'b1;
        rise_cycle       = cycle_cnt;
        while (reset_cnt == resets0 && wait_cnt < `FRAME_RESET_DELAY + 4) begin
            next_cycle();
            wait_cnt++;
        end
        if (reset_cnt == resets0) begin
            report_failure("read_frame_reset did not follow the read_index rise");
        end else begin
            compare_count("read_frame_reset delay", line_cnt_t'(reset_cycle - rise_cycle),
                          line_cnt_t'(`FRAME_RESET_DELAY));
        end
        repeat (2) next_cycle();
        for (int s = 0; s < starts; s++) begin
            if (accepted < height) begin
                push_line(accepted == 0);
                pulse_start();
                accepted++;
                // Start in the middle of a line
                repeat (40) next_cycle();
                pulse_start();
                while (line_ends - ends0 < accepted) begin
                    next_cycle();
                end
                // Start during the line gap
                pulse_start();
                repeat (`LINE_GAP + 2) next_cycle();
            end else begin
                // Height reached so the start is dropped
                pulse_start();
                repeat (20) next_cycle();
            end
        end
        while (exp_q.size() != 0) begin
            next_cycle();
        end
        compare_count("lines in frame", line_cnt_t'(line_ends - ends0), line_cnt_t'(exp_lines));
        compare_count("read_frame_reset pulses", line_cnt_t'(reset_cnt - resets0),
                      line_cnt_t'(1));
        read_index = 1'b0;
        repeat (10) next_cycle();
    endtask

    initial begin
        rst_n_eim        = 1'b0;
        read_index       = 1'b0;
        read_data_start  = 1'b0;
        dsp_image_height = '0;
        stall_pct        = 0;
        csi_gap_pct      = 0;
        cycle_cnt        = 0;
        line_seq         = 0;
        line_ends        = 0;
        reset_cnt        = 0;
        reset_cycle      = 0;
        beat_cnt         = 0;
        mismatch_cnt     = 0;
        fail_cnt         = 0;
        num_recs         = 0;
        limit_cycles     = 0;
        for (int i = 0; i < 64; i++) begin
            test_mem[i] = '0;
        end
        $readmemh("dv/readout_testdata.txt", test_mem);
        // Height of zero ends the record list
        while (num_recs < 15 && test_mem[4*num_recs] != 0) begin
            limit_cycles += int'(test_mem[4*num_recs]) * `NUM_ROIC * `WORDS_PER_ROIC * 4;
            num_recs++;
        end
        limit_cycles += 2000;

        repeat (16) @(posedge eim_clk);
        #1;
        rst_n_eim = 1'b1;
        check_quiet();

        for (int r = 0; r < num_recs; r++) begin
            run_frame(int'(test_mem[4*r]), int'(test_mem[4*r+1]),
                      int'(test_mem[4*r+2]), int'(test_mem[4*r+3]));
        end

        repeat (20) next_cycle();
        if (exp_q.size() != 0) begin
            report_failure("expected beats never arrived");
        end
        compare_count("frame resets in run", line_cnt_t'(reset_cnt), line_cnt_t'(num_recs));
        $display("Summary: %0d beats, %0d mismatches, %0d other errors",
                 beat_cnt, mismatch_cnt, fail_cnt);
        if (mismatch_cnt == 0 && fail_cnt == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    // Watchdog with a budget from the record heights
    initial begin
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge eim_clk);
        $display("Timeout after %0d cycles, the run did not complete", limit_cycles);
        $display("Testbench failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== dv/readout_testdata.txt ====
// Columns: image height, line starts to pulse, tready stall %, csi_done gap %
// All values hex; a record with height 0 ends the list
0002 0003 0000 0000
0003 0003 000f 000a
0001 0003 0028 001e
0002 0002 000a 0032
0004 0002 0014 0014
0000 0000 0000 0000

// ==== files.f ====
+incdir+src
src/readout_pkg.sv
src/frame_timing.sv
src/bank_sequencer.sv
src/read_data_mux.sv
src/readout_top.sv
dv/tb_clock_gen.sv
dv/tb_readout_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the readout testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -Wno-fatal -f files.f \
        --top-module tb_readout_top -o tb_readout_top; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/tb_readout_top)
sim_status=$?
echo "$sim_out"

if [ "$sim_status" -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "Testbench passed" <<< "$sim_out"; then
    exit 0
fi
exit 1
